// File: hw/dma_bank_reader.sv
`timescale 1ns/10ps
`default_nettype none

module dma_bank_reader
   import pcie_ts_pkg::*;
(
   input  wire       clk_pcie,
   input  wire       rst_pcie,
   input  wire       dma_write_start,
   input  wire       dma_write_end,
   input  wire       dma_raddr_en,
   output logic      dma_rdata_rdy,
   output dma_word_t dma_rdata,
   output logic      dma_rdata_busy,
   ts_bank_if.reader bank_1,
   ts_bank_if.reader bank_2
);

   localparam int SETUP_W = $clog2(SETUP_CYCLES);

   rd_state_t          state;
   rd_state_t          state_nxt;
   bank_sel_t          sel;
   logic               was_full;
   logic [SETUP_W-1:0] setup_cnt;
   bank_raddr_t        word_cnt;
   logic               data_vld;
   logic               sel_full;
   dma_word_t          sel_rdata;
   logic               clr_pulse;

   // byte 0 lands in the top byte
   function automatic dma_word_t byte_swap(input dma_word_t w);
      dma_word_t s;
      for (int i = 0; i < RD_BYTES; i++) begin
         s[8*i +: 8] = w[RD_WIDTH-8-8*i +: 8];
      end
      return s;
   endfunction

   assign sel_full     = (sel == BANK_1) ? bank_1.full : bank_2.full;
   assign sel_rdata    = (sel == BANK_1) ? bank_1.rdata : bank_2.rdata;

   // only a bank that was read out full gets released
   assign clr_pulse    = (state == RD_CLEAR) && was_full;
   assign bank_1.clear = clr_pulse && (sel == BANK_1);
   assign bank_2.clear = clr_pulse && (sel == BANK_2);
   assign bank_1.raddr = word_cnt;
   assign bank_2.raddr = word_cnt;

   ////////////////////////////////////////////////////////////
   // frame sequencer
   ////////////////////////////////////////////////////////////

   always_comb begin
      state_nxt = state;
      case (state)
         RD_IDLE:  if (dma_write_start) state_nxt = RD_CHECK;
         RD_CHECK: state_nxt = RD_ADDR;
         RD_ADDR:  if (dma_raddr_en) state_nxt = RD_SETUP;
         RD_SETUP: begin
            if (setup_cnt == SETUP_W'(SETUP_CYCLES - 1)) state_nxt = RD_DATA;
         end
         RD_DATA: begin
            if (word_cnt == bank_raddr_t'(RD_WORDS - 1)) state_nxt = RD_CLEAR;
         end
         RD_CLEAR: state_nxt = RD_END;
         RD_END:   if (dma_write_end) state_nxt = RD_IDLE;
         default:  state_nxt = RD_IDLE;
      endcase
   end

   always_ff @(posedge clk_pcie) begin
      if (rst_pcie) begin
         state     <= RD_IDLE;
         sel       <= BANK_1;
         was_full  <= 1'b0;
         setup_cnt <= '0;
         word_cnt  <= '0;
      end else begin
         state     <= state_nxt;
         setup_cnt <= (state == RD_SETUP) ? setup_cnt + 1'b1 : '0;
         word_cnt  <= (state == RD_DATA) ? word_cnt + 1'b1 : '0;
         if (state == RD_CHECK) begin
            was_full <= sel_full;
         end
         // a zero frame keeps the reader on the same bank
         if (clr_pulse) begin
            sel <= (sel == BANK_1) ? BANK_2 : BANK_1;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // output stage
   ////////////////////////////////////////////////////////////

   // bank rdata lags raddr by one cycle, output register adds one more
   always_ff @(posedge clk_pcie) begin
      if (rst_pcie) begin
         data_vld      <= 1'b0;
         dma_rdata_rdy <= 1'b0;
         dma_rdata     <= '0;
      end else begin
         data_vld      <= (state == RD_DATA);
         dma_rdata_rdy <= data_vld;
         if (data_vld && was_full) begin
            dma_rdata <= byte_swap(sel_rdata);
         end else begin
            dma_rdata <= '0;
         end
      end
   end

   always_ff @(posedge clk_pcie) begin
      if (rst_pcie) begin
         dma_rdata_busy <= 1'b0;
      end else if (dma_write_start) begin
         dma_rdata_busy <= 1'b1;
      end else if (dma_write_end) begin
         dma_rdata_busy <= 1'b0;
      end
   end

   // one frame is one unbroken run of ready cycles, never longer than a bank
   a_rdy_run_len: assert property (
      @(posedge clk_pcie) disable iff (rst_pcie)
      $rose(dma_rdata_rdy) |-> ##RD_WORDS !dma_rdata_rdy
   ) else $error("dma_bank_reader: ready held past one bank");

endmodule

`default_nettype wire

// File: hw/pcie_ts_config.svh
`ifndef PCIE_TS_CONFIG_SVH
`define PCIE_TS_CONFIG_SVH

////////////////////////////////////////////////////////////
// buffer sizes
////////////////////////////////////////////////////////////

// one TS write word
`define PCIE_TS_WR_WIDTH 256

// one DMA word toward the host
`define PCIE_TS_RD_WIDTH 64

// write words per bank
`define PCIE_TS_BANK_WORDS 4

////////////////////////////////////////////////////////////
// DMA timing
////////////////////////////////////////////////////////////

// wait after dma_raddr_en before data starts
`define PCIE_TS_SETUP_CYCLES 12

`endif

// File: hw/pcie_ts_pkg.sv
`default_nettype none

package pcie_ts_pkg;

`include "pcie_ts_config.svh"

   localparam int WR_WIDTH     = `PCIE_TS_WR_WIDTH;
   localparam int RD_WIDTH     = `PCIE_TS_RD_WIDTH;
   localparam int BANK_WORDS   = `PCIE_TS_BANK_WORDS;
   localparam int SETUP_CYCLES = `PCIE_TS_SETUP_CYCLES;

   // dma words per write word, per bank
   localparam int RD_PER_WR  = WR_WIDTH / RD_WIDTH;
   localparam int RD_WORDS   = BANK_WORDS * RD_PER_WR;
   localparam int SLICE_BITS = $clog2(RD_PER_WR);
   localparam int RD_BYTES   = RD_WIDTH / 8;

   typedef logic [WR_WIDTH-1:0]           ts_word_t;
   typedef logic [RD_WIDTH-1:0]           dma_word_t;
   typedef logic [$clog2(BANK_WORDS)-1:0] bank_waddr_t;
   typedef logic [$clog2(RD_WORDS)-1:0]   bank_raddr_t;

   typedef enum logic {BANK_1, BANK_2} bank_sel_t;

   // reader sequence, one frame per dma_write_start
   typedef enum logic [3:0] {
      RD_IDLE, RD_CHECK, RD_ADDR, RD_SETUP, RD_DATA, RD_CLEAR, RD_END
   } rd_state_t;

endpackage

`default_nettype wire

// File: hw/pcie_ts_rd.sv
`timescale 1ns/10ps
`default_nettype none

module pcie_ts_rd
   import pcie_ts_pkg::*;
(
   input  wire           clk_pcie,
   input  wire           rst_pcie,

   // TS write bursts
   input  wire           ts_ram_wr,
   input  wire ts_word_t ts_ram_wdata,

   // DMA read handshake
   input  wire           dma_write_start,
   input  wire           dma_write_end,
   input  wire           dma_raddr_en,
   input  wire [31:0]    dma_raddr,
   output logic          dma_rdata_rdy,
   output dma_word_t     dma_rdata,
   output logic          dma_rdata_busy,

   // bank status
   output logic          ram_full_1,
   output logic          ram_full_2
);

   // dma_raddr is not decoded, a frame always streams the whole bank

   ts_bank_if bank_1 ();
   ts_bank_if bank_2 ();

   ////////////////////////////////////////////////////////////
   // ping-pong banks
   ////////////////////////////////////////////////////////////

   ts_bank i_bank_1 (
      .clk_pcie (clk_pcie),
      .rst_pcie (rst_pcie),
      .bank     (bank_1.bank)
   );

   ts_bank i_bank_2 (
      .clk_pcie (clk_pcie),
      .rst_pcie (rst_pcie),
      .bank     (bank_2.bank)
   );

   ts_bank_writer i_writer (
      .clk_pcie     (clk_pcie),
      .rst_pcie     (rst_pcie),
      .ts_ram_wr    (ts_ram_wr),
      .ts_ram_wdata (ts_ram_wdata),
      .bank_1       (bank_1.writer),
      .bank_2       (bank_2.writer)
   );

   dma_bank_reader i_reader (
      .clk_pcie        (clk_pcie),
      .rst_pcie        (rst_pcie),
      .dma_write_start (dma_write_start),
      .dma_write_end   (dma_write_end),
      .dma_raddr_en    (dma_raddr_en),
      .dma_rdata_rdy   (dma_rdata_rdy),
      .dma_rdata       (dma_rdata),
      .dma_rdata_busy  (dma_rdata_busy),
      .bank_1          (bank_1.reader),
      .bank_2          (bank_2.reader)
   );

   assign ram_full_1 = bank_1.full;
   assign ram_full_2 = bank_2.full;

endmodule

`default_nettype wire

// File: hw/ts_bank.sv
`timescale 1ns/10ps
`default_nettype none

module ts_bank
   import pcie_ts_pkg::*;
(
   input wire      clk_pcie,
   input wire      rst_pcie,
   ts_bank_if.bank bank
);

   ts_word_t              mem [BANK_WORDS];
   bank_waddr_t           rd_word;
   logic [SLICE_BITS-1:0] rd_slice;

   // upper bits pick the write word, lower bits the 64-bit slice
   assign rd_word  = bank.raddr[$bits(bank_raddr_t)-1:SLICE_BITS];
   assign rd_slice = bank.raddr[SLICE_BITS-1:0];

   ////////////////////////////////////////////////////////////
   // memory
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_pcie) begin
      if (bank.wr) begin
         mem[bank.waddr] <= bank.wdata;
      end
   end

   // low slice of a word comes out first
   always_ff @(posedge clk_pcie) begin
      bank.rdata <= mem[rd_word][rd_slice*RD_WIDTH +: RD_WIDTH];
   end

   ////////////////////////////////////////////////////////////
   // full flag
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_pcie) begin
      if (rst_pcie) begin
         bank.full <= 1'b0;
      end else if (bank.wr && bank.last) begin
         bank.full <= 1'b1;
      end else if (bank.clear) begin
         bank.full <= 1'b0;
      end
   end

   // writer must leave a full bank alone until the reader clears it
   a_no_wr_when_full: assert property (
      @(posedge clk_pcie) disable iff (rst_pcie)
      bank.wr |-> !bank.full
   ) else $error("ts_bank: write while bank is full");

endmodule

`default_nettype wire

// File: hw/ts_bank_if.sv
`timescale 1ns/10ps
`default_nettype none

interface ts_bank_if
   import pcie_ts_pkg::*;
();

   // write side
   logic        wr;
   logic        last;
   bank_waddr_t waddr;
   ts_word_t    wdata;

   // bank status
   logic        full;

   // read side
   logic        clear;
   bank_raddr_t raddr;
   dma_word_t   rdata;

   modport writer (output wr, last, waddr, wdata, input full);

   modport reader (output clear, raddr, input full, rdata);

   modport bank (
      input  wr, last, waddr, wdata, clear, raddr,
      output full, rdata
   );

endinterface

`default_nettype wire

// File: hw/ts_bank_writer.sv
`timescale 1ns/10ps
`default_nettype none

module ts_bank_writer
   import pcie_ts_pkg::*;
(
   input wire          clk_pcie,
   input wire          rst_pcie,
   input wire          ts_ram_wr,
   input wire ts_word_t ts_ram_wdata,
   ts_bank_if.writer   bank_1,
   ts_bank_if.writer   bank_2
);

   bank_sel_t                      sel;
   logic                           ts_ram_wr_r;
   logic                           active;
   logic [$bits(bank_waddr_t):0]   word_cnt;
   logic                           pend_vld;
   ts_word_t                       pend_data;
   bank_waddr_t                    pend_addr;
   logic                           tgt_full;
   logic                           start;
   logic                           take;
   logic                           burst_end;
   logic                           wr;

   assign tgt_full  = (sel == BANK_1) ? bank_1.full : bank_2.full;

   // new burst only on a rising edge into a bank with room
   assign start     = ts_ram_wr && !ts_ram_wr_r && !active && !tgt_full;
   assign burst_end = active && !ts_ram_wr;

   // words past the bank size are dropped
   assign take      = (start || active) && ts_ram_wr && (word_cnt < BANK_WORDS);

   // a held word goes out when the next one arrives or the burst ends,
   // so the final write can carry the last marker
   assign wr        = pend_vld && (take || burst_end);

   ////////////////////////////////////////////////////////////
   // burst control
   ////////////////////////////////////////////////////////////

   always_ff @(posedge clk_pcie) begin
      if (rst_pcie) begin
         sel         <= BANK_1;
         ts_ram_wr_r <= 1'b0;
         active      <= 1'b0;
         word_cnt    <= '0;
         pend_vld    <= 1'b0;
      end else begin
         ts_ram_wr_r <= ts_ram_wr;
         if (start) begin
            active <= 1'b1;
         end else if (burst_end) begin
            active <= 1'b0;
         end
         if (burst_end) begin
            word_cnt <= '0;
            pend_vld <= 1'b0;
            sel      <= (sel == BANK_1) ? BANK_2 : BANK_1;
         end else if (take) begin
            word_cnt <= word_cnt + 1'b1;
            pend_vld <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk_pcie) begin
      if (take) begin
         pend_data <= ts_ram_wdata;
         pend_addr <= bank_waddr_t'(word_cnt);
      end
   end

   // only the target bank sees the strobe
   assign bank_1.wr    = wr && (sel == BANK_1);
   assign bank_2.wr    = wr && (sel == BANK_2);
   assign bank_1.last  = burst_end;
   assign bank_2.last  = burst_end;
   assign bank_1.waddr = pend_addr;
   assign bank_2.waddr = pend_addr;
   assign bank_1.wdata = pend_data;
   assign bank_2.wdata = pend_data;

endmodule

`default_nettype wire

// File: run_sim.sh
#!/usr/bin/env bash
# build and run the testbench with Verilator, pass only on the pass line in the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module tb_pcie_ts_rd \
   -f tb.f -o sim_tb > build.log 2>&1 \
   && ./obj_dir/sim_tb > sim.log 2>&1 \
   || echo "simulation did not build or run cleanly"

cat sim.log 2>/dev/null
grep -qx "RESULT: PASS" sim.log && exit 0 || exit 1

// File: tb.f
+incdir+hw
hw/pcie_ts_pkg.sv
hw/ts_bank_if.sv
hw/ts_bank.sv
hw/ts_bank_writer.sv
hw/dma_bank_reader.sv
hw/pcie_ts_rd.sv
verif/tb_pcie_ts_rd.sv

// File: verif/tb_pcie_ts_rd.sv
`timescale 1ns/10ps
`default_nettype none

module tb_pcie_ts_rd
   import pcie_ts_pkg::*;
();

   localparam int NUM_ROWS      = 11;
   localparam int WAIT_LIMIT    = 200;
   localparam int SETTLE_CYCLES = 3;

   typedef enum logic [1:0] {OP_BURST, OP_FRAME} op_t;
   typedef enum logic [1:0] {FR_NONE, FR_ZERO, FR_DATA} frame_t;

   // table row holds operation, burst length, flags after it and frame kind
   typedef struct packed {
      op_t        op;
      logic [3:0] len;
      logic       full_1;
      logic       full_2;
      frame_t     kind;
   } row_t;

   logic      clk_pcie = 1'b0;
   logic      rst_pcie;
   logic      ts_ram_wr;
   ts_word_t  ts_ram_wdata;
   logic      dma_write_start;
   logic      dma_write_end;
   logic      dma_raddr_en;
   logic [31:0] dma_raddr;
   logic      dma_rdata_rdy;
   dma_word_t dma_rdata;
   logic      dma_rdata_busy;
   logic      ram_full_1;
   logic      ram_full_2;

   row_t      stim_rows [NUM_ROWS];
   int        errors = 0;
   int        tests_run = 0;
   int        tests_failed = 0;
   logic      timed_out = 1'b0;

   // reference model of the ping-pong buffer
   ts_word_t  image_q [$];
   logic      model_full [2];
   int        wr_sel;
   int        rd_sel;

   pcie_ts_rd i_pcie_ts_rd (
      .clk_pcie        (clk_pcie),
      .rst_pcie        (rst_pcie),
      .ts_ram_wr       (ts_ram_wr),
      .ts_ram_wdata    (ts_ram_wdata),
      .dma_write_start (dma_write_start),
      .dma_write_end   (dma_write_end),
      .dma_raddr_en    (dma_raddr_en),
      .dma_raddr       (dma_raddr),
      .dma_rdata_rdy   (dma_rdata_rdy),
      .dma_rdata       (dma_rdata),
      .dma_rdata_busy  (dma_rdata_busy),
      .ram_full_1      (ram_full_1),
      .ram_full_2      (ram_full_2)
   );

   always #50 clk_pcie = ~clk_pcie;

   ////////////////////////////////////////////////////////////
   // compare tasks and helpers
   ////////////////////////////////////////////////////////////

   task automatic check_word(input string name, input dma_word_t got, input dma_word_t exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Mismatch at %0t: %s is %b, expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic report_timeout(input string what);
      $display("Timeout at %0t: %s", $time, what);
      errors++;
      timed_out = 1'b1;
   endtask

   // first byte on the wire sits in the top byte
   function automatic dma_word_t reverse_bytes(input dma_word_t w);
      dma_word_t r;
      for (int b = 0; b < RD_BYTES; b++) begin
         r[RD_WIDTH-1-8*b -: 8] = w[8*b +: 8];
      end
      return r;
   endfunction

   function automatic ts_word_t random_word();
      ts_word_t w;
      for (int i = 0; i < WR_WIDTH / 32; i++) begin
         w[32*i +: 32] = $urandom;
      end
      return w;
   endfunction

   task automatic load_rows();
      stim_rows[0]  = '{OP_FRAME, 4'd0, 1'b0, 1'b0, FR_ZERO};
      stim_rows[1]  = '{OP_BURST, 4'd4, 1'b1, 1'b0, FR_NONE};
      stim_rows[2]  = '{OP_BURST, 4'd4, 1'b1, 1'b1, FR_NONE};
      // both banks full so this burst is dropped
      stim_rows[3]  = '{OP_BURST, 4'd4, 1'b1, 1'b1, FR_NONE};
      stim_rows[4]  = '{OP_FRAME, 4'd0, 1'b0, 1'b1, FR_DATA};
      stim_rows[5]  = '{OP_FRAME, 4'd0, 1'b0, 1'b0, FR_DATA};
      stim_rows[6]  = '{OP_BURST, 4'd4, 1'b1, 1'b0, FR_NONE};
      stim_rows[7]  = '{OP_FRAME, 4'd0, 1'b0, 1'b0, FR_DATA};
      stim_rows[8]  = '{OP_BURST, 4'd6, 1'b0, 1'b1, FR_NONE};
      stim_rows[9]  = '{OP_FRAME, 4'd0, 1'b0, 1'b0, FR_DATA};
      stim_rows[10] = '{OP_FRAME, 4'd0, 1'b0, 1'b0, FR_ZERO};
   endtask

   ////////////////////////////////////////////////////////////
   // operations
   ////////////////////////////////////////////////////////////

   task automatic run_burst(input int len);
      ts_word_t w;
      logic     accept;
      accept = !model_full[wr_sel];
      for (int i = 0; i < len; i++) begin
         w = random_word();
         @(posedge clk_pcie);
         ts_ram_wr    <= 1'b1;
         ts_ram_wdata <= w;
         if (accept && i < BANK_WORDS) begin
            image_q.push_back(w);
         end
      end
      @(posedge clk_pcie);
      ts_ram_wr    <= 1'b0;
      ts_ram_wdata <= '0;
      if (accept) begin
         model_full[wr_sel] = 1'b1;
         wr_sel = 1 - wr_sel;
      end
   endtask

   task automatic run_frame(input frame_t kind);
      int        n;
      int        rdy_cnt;
      logic      seen_rdy;
      logic      done;
      ts_word_t  image [BANK_WORDS];
      dma_word_t exp;
      dma_word_t got [RD_WORDS];
      @(posedge clk_pcie);
      dma_write_start <= 1'b1;
      @(posedge clk_pcie);
      dma_write_start <= 1'b0;
      n = 0;
      @(negedge clk_pcie);
      while (dma_rdata_busy !== 1'b1 && n < WAIT_LIMIT) begin
         @(negedge clk_pcie);
         n++;
      end
      if (dma_rdata_busy !== 1'b1) begin
         report_timeout("dma_rdata_busy did not rise after dma_write_start");
         return;
      end
      @(posedge clk_pcie);
      dma_raddr_en <= 1'b1;
      dma_raddr    <= $urandom;
      @(posedge clk_pcie);
      dma_raddr_en <= 1'b0;
      // collect the ready run while busy holds
      n        = 0;
      rdy_cnt  = 0;
      seen_rdy = 1'b0;
      done     = 1'b0;
      while (!done && n < WAIT_LIMIT) begin
         @(negedge clk_pcie);
         n++;
         check_flag("dma_rdata_busy", dma_rdata_busy, 1'b1);
         if (dma_rdata_rdy === 1'b1) begin
            if (rdy_cnt < RD_WORDS) begin
               got[rdy_cnt] = dma_rdata;
            end
            seen_rdy = 1'b1;
            rdy_cnt++;
         end else if (seen_rdy) begin
            done = 1'b1;
         end
      end
      if (!done) begin
         report_timeout("no complete dma_rdata_rdy run in the frame");
         return;
      end
      @(posedge clk_pcie);
      dma_write_end <= 1'b1;
      @(posedge clk_pcie);
      dma_write_end <= 1'b0;
      n = 0;
      @(negedge clk_pcie);
      while (dma_rdata_busy !== 1'b0 && n < WAIT_LIMIT) begin
         @(negedge clk_pcie);
         n++;
      end
      if (dma_rdata_busy !== 1'b0) begin
         report_timeout("dma_rdata_busy did not fall after dma_write_end");
         return;
      end
      if (rdy_cnt != RD_WORDS) begin
         $display("frame gave %0d ready cycles, expected %0d", rdy_cnt, RD_WORDS);
         errors++;
      end
      if (kind == FR_DATA) begin
         if (image_q.size() < BANK_WORDS) begin
            $display("reference model holds no bank image for a data frame");
            errors++;
         end else begin
            for (int i = 0; i < BANK_WORDS; i++) begin
               image[i] = image_q.pop_front();
            end
         end
         model_full[rd_sel] = 1'b0;
         rd_sel = 1 - rd_sel;
      end
      // write word 0 first and the low slice of each word first
      for (int k = 0; k < RD_WORDS && k < rdy_cnt; k++) begin
         if (kind == FR_DATA) begin
            exp = reverse_bytes(image[k / RD_PER_WR][(k % RD_PER_WR)*RD_WIDTH +: RD_WIDTH]);
         end else begin
            exp = '0;
         end
         check_word($sformatf("dma_rdata word %0d", k), got[k], exp);
      end
   endtask

   task automatic wait_flags(input logic exp_1, input logic exp_2);
      int n;
      n = 0;
      @(negedge clk_pcie);
      while ((ram_full_1 !== exp_1 || ram_full_2 !== exp_2) && n < WAIT_LIMIT) begin
         @(negedge clk_pcie);
         n++;
      end
      if (ram_full_1 !== exp_1 || ram_full_2 !== exp_2) begin
         report_timeout("bank full flags never reached the expected state");
      end
   endtask

   ////////////////////////////////////////////////////////////
   // main sequence
   ////////////////////////////////////////////////////////////

   initial begin
      int err_before;
      void'($urandom(32'h5a2a_77ad));
      rst_pcie        = 1'b1;
      ts_ram_wr       = 1'b0;
      ts_ram_wdata    = '0;
      dma_write_start = 1'b0;
      dma_write_end   = 1'b0;
      dma_raddr_en    = 1'b0;
      dma_raddr       = '0;
      model_full[0]   = 1'b0;
      model_full[1]   = 1'b0;
      wr_sel          = 0;
      rd_sel          = 0;
      load_rows();
      repeat (10) @(posedge clk_pcie);
      rst_pcie <= 1'b0;

      // idle outputs right after reset
      @(negedge clk_pcie);
      check_flag("dma_rdata_rdy", dma_rdata_rdy, 1'b0);
      check_flag("dma_rdata_busy", dma_rdata_busy, 1'b0);
      check_flag("ram_full_1", ram_full_1, 1'b0);
      check_flag("ram_full_2", ram_full_2, 1'b0);
      check_word("dma_rdata", dma_rdata, '0);
      tests_run++;
      if (errors != 0) begin
         tests_failed++;
      end
      $display("test reset: %s", (errors == 0) ? "ok" : "failed");

      for (int t = 0; t < NUM_ROWS && !timed_out; t++) begin
         err_before = errors;
         if (stim_rows[t].op == OP_BURST) begin
            run_burst(int'(stim_rows[t].len));
         end else begin
            run_frame(stim_rows[t].kind);
         end
         if (!timed_out) begin
            wait_flags(stim_rows[t].full_1, stim_rows[t].full_2);
         end
         repeat (SETTLE_CYCLES) @(posedge clk_pcie);
         @(negedge clk_pcie);
         check_flag("ram_full_1", ram_full_1, stim_rows[t].full_1);
         check_flag("ram_full_2", ram_full_2, stim_rows[t].full_2);
         tests_run++;
         if (errors != err_before) begin
            tests_failed++;
         end
         $display("test %0d %s: %s", t, stim_rows[t].op.name(),
                  (errors == err_before) ? "ok" : "failed");
      end

      $display("tests %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
      if (errors == 0) begin
         $display("RESULT: PASS");
      end else begin
         $display("RESULT: FAIL");
      end
      $finish;
   end

endmodule

`default_nettype wire
